// File: dv/lsu_tb.sv
`timescale 1ns/10ps

module lsu_tb;
    import isa_pkg::*;
    import lsq_pkg::*;

    localparam int max_cycles = 4000; // Longest phase sequence is well under 2000 cycles

    typedef struct packed {
        logic [31:0] value;
        pr_idx_t     dest_pr;
        rob_idx_t    rob_entry;
    } exp_t;

    typedef struct packed {
        sq_idx_t     idx;
        rv_inst_t    inst;
        logic [31:0] base;
        logic [31:0] value;
        ls_op_t      op;
    } store_t;

    logic          clock;
    logic          reset;
    issue_pkt_t    load_issue;
    logic          load_ready;
    logic          sq_alloc;
    sq_idx_t       sq_alloc_idx;
    logic          sq_resolve;
    sq_idx_t       sq_resolve_idx;
    rv_inst_t      sq_resolve_inst;
    logic [31:0]   sq_resolve_base;
    logic [31:0]   sq_resolve_value;
    ls_op_t        sq_resolve_op;
    logic          sq_commit;
    logic          complete_stall = 1'b0;
    logic          want_to_complete;
    complete_pkt_t complete;
    logic          sq_full;

    logic [7:0] ref_mem [64];  // Program-order byte image of words 0..15
    exp_t       exp_q [$];
    exp_t       done_exp;
    logic       fwd_all_load;  // Load under test is fully covered by older stores
    logic       store_held;    // An older store is still unresolved
    logic       stall_on;
    int         accepted;
    int         completed;
    int         allocs;        // Stores allocated so far
    int         cycles;

    lsu_top #(
        .SQ_DEPTH  (8),
        .MEM_WORDS (256)
    ) uut (
        .clock            (clock),
        .reset            (reset),
        .load_issue       (load_issue),
        .load_ready       (load_ready),
        .sq_alloc         (sq_alloc),
        .sq_alloc_idx     (sq_alloc_idx),
        .sq_resolve       (sq_resolve),
        .sq_resolve_idx   (sq_resolve_idx),
        .sq_resolve_inst  (sq_resolve_inst),
        .sq_resolve_base  (sq_resolve_base),
        .sq_resolve_value (sq_resolve_value),
        .sq_resolve_op    (sq_resolve_op),
        .sq_commit        (sq_commit),
        .complete_stall   (complete_stall),
        .want_to_complete (want_to_complete),
        .complete         (complete),
        .sq_full          (sq_full)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    task automatic stop_on_error();
        $display("Test failures found");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        assert (actual === expected) else begin
            $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, expected, actual);
            stop_on_error();
        end
    endtask

    function automatic logic [2:0] funct3_of(ls_op_t op);
        case (op)
            LB, SB:  return 3'd0;
            LH, SH:  return 3'd1;
            LBU:     return 3'd4;
            LHU:     return 3'd5;
            default: return 3'd2;
        endcase
    endfunction

    // Random byte address, aligned to the access width
    function automatic logic [5:0] pick_addr(ls_op_t op);
        logic [5:0] a;
        a = 6'($urandom);
        case (op)
            LH, LHU, SH: a[0] = 1'b0;
            LW, SW:      a[1:0] = 2'b00;
            default:     a = a;
        endcase
        return a;
    endfunction

    // Little-endian value of a load from the reference image
    function automatic logic [31:0] expected_load(ls_op_t op, logic [5:0] a);
        logic [7:0] b0;
        logic [7:0] b1;
        b0 = ref_mem[a];
        b1 = ref_mem[a + 6'd1];
        case (op)
            LB:      return {{24{b0[7]}}, b0};
            LBU:     return {24'h0, b0};
            LH:      return {{16{b1[7]}}, b1, b0};
            LHU:     return {16'h0, b1, b0};
            default: return {ref_mem[a + 6'd3], ref_mem[a + 6'd2], b1, b0};
        endcase
    endfunction

    task automatic alloc_store(input ls_op_t op, input logic [5:0] addr,
                               input logic [31:0] value, output store_t st);
        logic [11:0] imm;
        imm = 12'($urandom);
        st = '0;
        st.op = op;
        st.value = value;
        st.inst.s.imm_hi = imm[11:5];
        st.inst.s.rs2 = 5'($urandom);
        st.inst.s.rs1 = 5'($urandom);
        st.inst.s.funct3 = funct3_of(op);
        st.inst.s.imm_lo = imm[4:0];
        st.inst.s.opcode = 7'b0100011;
        st.base = {26'h0, addr} - {{20{imm[11]}}, imm}; // Base plus immediate lands on addr
        @(negedge clock);
        while (sq_full) @(negedge clock);
        st.idx = sq_alloc_idx;
        check_value("sq_alloc_idx", sq_alloc_idx, allocs % 8); // Circular tail of 8 entries
        allocs++;
        @(posedge clock);
        sq_alloc <= 1'b1;
        @(posedge clock);
        sq_alloc <= 1'b0;
        ref_mem[addr] = value[7:0];
        if (op != SB) ref_mem[addr + 6'd1] = value[15:8];
        if (op == SW) begin
            ref_mem[addr + 6'd2] = value[23:16];
            ref_mem[addr + 6'd3] = value[31:24];
        end
    endtask

    task automatic resolve_store(input store_t st);
        @(posedge clock);
        sq_resolve       <= 1'b1;
        sq_resolve_idx   <= st.idx;
        sq_resolve_inst  <= st.inst;
        sq_resolve_base  <= st.base;
        sq_resolve_value <= st.value;
        sq_resolve_op    <= st.op;
        @(posedge clock);
        sq_resolve <= 1'b0;
    endtask

    task automatic commit_store();
        @(posedge clock);
        sq_commit <= 1'b1;
        @(posedge clock);
        sq_commit <= 1'b0;
    endtask

    task automatic store_and_commit(input ls_op_t op, input logic [5:0] addr,
                                    input logic [31:0] value);
        store_t st;
        alloc_store(op, addr, value, st);
        resolve_store(st);
        commit_store();
    endtask

    task automatic issue_load(input ls_op_t op, input logic [5:0] addr, input logic all_fwd);
        issue_pkt_t  pkt;
        exp_t        e;
        logic [11:0] imm;
        imm = 12'($urandom);
        pkt = '0;
        pkt.valid = 1'b1;
        pkt.inst.i.imm = imm;
        pkt.inst.i.rs1 = 5'($urandom);
        pkt.inst.i.funct3 = funct3_of(op);
        pkt.inst.i.rd = 5'($urandom);
        pkt.inst.i.opcode = 7'b0000011;
        pkt.base = {26'h0, addr} - {{20{imm[11]}}, imm};
        pkt.op = op;
        pkt.dest_pr = 6'($urandom);
        pkt.rob_entry = 5'($urandom);
        e.value = expected_load(op, addr);
        e.dest_pr = pkt.dest_pr;
        e.rob_entry = pkt.rob_entry;
        @(negedge clock);
        while (!load_ready) @(negedge clock);
        pkt.sq_tail = sq_alloc_idx;   // Stores from here on are younger
        exp_q.push_back(e);
        @(posedge clock);
        load_issue   <= pkt;
        fwd_all_load <= all_fwd;
        @(posedge clock);
        load_issue.valid <= 1'b0;
        fwd_all_load     <= 1'b0;
    endtask

    task automatic wait_done();
        @(negedge clock);
        while (exp_q.size() != 0 || !load_ready) @(negedge clock);
    endtask

    // Completion checks
    always @(posedge clock) begin
        if (!reset) begin
            if (load_issue.valid && load_ready) accepted++;
            if (want_to_complete && !complete_stall) begin
                completed++;
                if (exp_q.size() == 0) begin
                    $display("Load completed at %0t with no load outstanding", $time);
                    stop_on_error();
                end else begin
                    done_exp = exp_q.pop_front();
                    check_value("complete.valid", complete.valid, 1'b1);
                    check_value("complete.dest_value", complete.dest_value, done_exp.value);
                    check_value("complete.dest_pr", complete.dest_pr, done_exp.dest_pr);
                    check_value("complete.rob_entry", complete.rob_entry, done_exp.rob_entry);
                end
            end
        end
    end

    always @(posedge clock) begin
        complete_stall <= stall_on && ($urandom_range(0, 2) != 0);
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("Timeout: run did not finish within %0d cycles", max_cycles);
            stop_on_error();
        end
    end

    fwd_latency_check: assert property (@(posedge clock) disable iff (reset)
        load_issue.valid && load_ready && fwd_all_load |=> !want_to_complete ##1 want_to_complete)
        else begin
            $display("Fully forwarded load not offered exactly 2 cycles after accept at %0t", $time);
            stop_on_error();
        end

    stall_hold_check: assert property (@(posedge clock) disable iff (reset)
        want_to_complete && complete_stall |=> want_to_complete && $stable(complete))
        else begin
            $display("Completion changed or dropped under complete_stall at %0t", $time);
            stop_on_error();
        end

    release_check: assert property (@(posedge clock) disable iff (reset)
        want_to_complete && !complete_stall |=> load_ready)
        else begin
            $display("Load unit not back to idle after completion at %0t", $time);
            stop_on_error();
        end

    unresolved_check: assert property (@(posedge clock) disable iff (reset)
        store_held |-> !want_to_complete)
        else begin
            $display("Load completed past an unresolved older store at %0t", $time);
            stop_on_error();
        end

    initial begin
        store_t      st_a;
        store_t      st_b;
        logic [5:0]  w;
        logic [31:0] value;
        ls_op_t      op;
        void'($urandom(32'h44b32f15));
        reset = 1'b1;
        load_issue = '0;
        sq_alloc = 1'b0;
        sq_resolve = 1'b0;
        sq_resolve_idx = '0;
        sq_resolve_inst = '0;
        sq_resolve_base = '0;
        sq_resolve_value = '0;
        sq_resolve_op = SW;
        sq_commit = 1'b0;
        fwd_all_load = 1'b0;
        store_held = 1'b0;
        stall_on = 1'b0;
        accepted = 0;
        completed = 0;
        allocs = 0;
        cycles = 0;
        repeat (2) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        check_value("load_ready", load_ready, 1'b1);
        check_value("want_to_complete", want_to_complete, 1'b0);
        check_value("sq_full", sq_full, 1'b0);

        // Every word written once before any read
        for (int k = 0; k < 16; k++) store_and_commit(SW, 6'(4 * k), $urandom);
        for (int k = 0; k < 6; k++) begin
            store_and_commit(SB, pick_addr(SB), $urandom);
            store_and_commit(SH, pick_addr(SH), $urandom);
        end
        for (int k = 0; k < 16; k++) issue_load(LW, 6'(4 * k), 1'b0);
        wait_done();

        // Full forwarding, younger store allocated on the same edge the load is accepted
        w = pick_addr(SW);
        alloc_store(SW, w, $urandom, st_a);
        resolve_store(st_a);
        fork
            issue_load(LW, w, 1'b1);
            alloc_store(SW, w, $urandom, st_b);
        join
        resolve_store(st_b);
        wait_done();
        issue_load(LH, w + 6'd2, 1'b1);
        issue_load(LB, w + 6'd1, 1'b1);
        wait_done();
        commit_store();
        commit_store();

        // Partial merge of forwarded and memory bytes
        for (int k = 0; k < 4; k++) begin
            op = (k % 2 == 0) ? SB : SH;
            w = pick_addr(op);
            alloc_store(op, w, $urandom, st_a);
            resolve_store(st_a);
            issue_load(LW, {w[5:2], 2'b00}, 1'b0);
            wait_done();
            commit_store();
        end

        // Unresolved older store stalls the load; a younger one is ignored
        w = pick_addr(SW);
        alloc_store(SH, w + 6'd2, $urandom, st_a);
        store_held <= 1'b1;
        issue_load(LW, w, 1'b0);
        alloc_store(SW, w, $urandom, st_b);
        resolve_store(st_b);
        repeat ($urandom_range(3, 10)) @(posedge clock);
        resolve_store(st_a);
        store_held <= 1'b0;
        wait_done();
        commit_store();
        commit_store();

        // Sign and zero extension at every legal offset
        for (int p = 0; p < 2; p++) begin
            w = pick_addr(SW);
            value = ($urandom & 32'h7f7f7f7f) | ((p == 0) ? 32'h00800080 : 32'h80008000);
            store_and_commit(SW, w, value);
            for (int off = 0; off < 4; off++) begin
                issue_load(LB, w + 6'(off), 1'b0);
                issue_load(LBU, w + 6'(off), 1'b0);
            end
            for (int off = 0; off < 4; off += 2) begin
                issue_load(LH, w + 6'(off), 1'b0);
                issue_load(LHU, w + 6'(off), 1'b0);
            end
            wait_done();
        end

        // Random back-pressure on completion
        stall_on <= 1'b1;
        for (int k = 0; k < 12; k++) begin
            if (k % 4 == 0) store_and_commit(SW, pick_addr(SW), $urandom);
            op = ls_op_t'($urandom_range(0, 4));
            issue_load(op, pick_addr(op), 1'b0);
        end
        wait_done();
        stall_on <= 1'b0;

        repeat (4) @(posedge clock);
        check_value("completions vs accepted loads", completed, accepted);
        check_value("outstanding loads", exp_q.size(), 0);
        $display("All tests passed!");
        $finish;
    end

endmodule

// File: logic/data_mem.sv
`timescale 1ns/10ps

module data_mem #(
    parameter int MEM_WORDS = 256
) (
    input  logic              clock,
    input  logic              reset,
    input  lsq_pkg::mem_req_t req,
    output logic              rd_valid,
    output logic [31:0]       rd_data
);

    localparam int aw = $clog2(MEM_WORDS);

    logic [31:0]   mem [MEM_WORDS];
    logic [aw-1:0] idx;

    assign idx = req.word_addr[aw-1:0];

    always_ff @(posedge clock) begin
        if (req.valid && req.write) begin
            for (int b = 0; b < 4; b++) begin
                if (req.be[b]) mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
            end
        end
        if (req.valid && !req.write) rd_data <= mem[idx];
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= req.valid && !req.write; // One cycle read latency
        end
    end

endmodule

// File: logic/isa_pkg.sv
package isa_pkg;

    localparam int xlen = 32;

    typedef enum logic [2:0] {
        LB,
        LH,
        LW,
        LBU,
        LHU,
        SB,
        SH,
        SW
    } ls_op_t;

    // Load encoding
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_view_t;

    // Store encoding, immediate split around rs2/rs1
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_view_t;

    typedef union packed {
        i_view_t i;
        s_view_t s;
    } rv_inst_t;

    function automatic logic [xlen-1:0] i_imm(rv_inst_t inst);
        return {{20{inst.i.imm[11]}}, inst.i.imm};
    endfunction

    function automatic logic [xlen-1:0] s_imm(rv_inst_t inst);
        return {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
    endfunction

endpackage

// File: logic/load_unit.sv
`timescale 1ns/10ps

module load_unit (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   complete_stall,
    input  lsq_pkg::issue_pkt_t    issue,
    output logic                   ready,
    output logic                   want_to_complete,
    output lsq_pkg::complete_pkt_t result,
    output lsq_pkg::sq_lookup_t    lookup,
    input  lsq_pkg::sq_result_t    fwd,
    output lsq_pkg::mem_req_t      mem_req,
    input  logic                   grant,
    input  logic                   rd_valid,
    input  logic [31:0]            rd_data
);
    import isa_pkg::*;
    import lsq_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_MEM,
        ST_OUTPUT
    } state_t;

    // Load in flight
    typedef struct packed {
        pr_idx_t         dest_pr;
        rob_idx_t        rob_entry;
        sq_idx_t         tail_pos;
        logic [xlen-1:0] addr;
        ls_op_t          op;
        logic [3:0]      usebytes;
        logic [3:0]      fwd_bytes;
        logic [xlen-1:0] data;     // Lane aligned, as in memory
    } load_reg_t;

    state_t          state;
    load_reg_t       ld;
    logic            req_pending;
    logic            accept;
    logic [xlen-1:0] new_addr;
    logic [3:0]      new_usebytes;
    logic [3:0]      hit_bytes;
    logic            full_fwd;
    logic [xlen-1:0] merged;
    logic [xlen-1:0] shifted;
    logic [xlen-1:0] wb_data;

    assign ready  = (state == ST_IDLE);
    assign accept = ready && issue.valid;

    assign new_addr = issue.base + i_imm(issue.inst);

    // Bytes touched within the word
    always_comb begin
        case (issue.op)
            LB, LBU: new_usebytes = 4'b0001 << new_addr[1:0];
            LH, LHU: new_usebytes = 4'b0011 << new_addr[1:0];
            LW:      new_usebytes = 4'b1111;
            default: new_usebytes = 4'b0000;
        endcase
    end

    assign lookup.word_addr = ld.addr[xlen-1:2];
    assign lookup.tail_pos  = ld.tail_pos;

    assign hit_bytes = fwd.usebytes & ld.usebytes;
    assign full_fwd  = (hit_bytes == ld.usebytes);

    // Forwarded bytes win over memory
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            merged[8*b +: 8] = ld.fwd_bytes[b] ? ld.data[8*b +: 8] : rd_data[8*b +: 8];
        end
    end

    assign mem_req.valid     = req_pending;
    assign mem_req.write     = 1'b0;
    assign mem_req.word_addr = ld.addr[xlen-1:2];
    assign mem_req.be        = ld.usebytes;
    assign mem_req.wdata     = '0;

    // Move the addressed byte or half down to bit 0
    assign shifted = ld.data >> {ld.addr[1:0], 3'b000};

    always_comb begin
        case (ld.op)
            LB:      wb_data = {{24{shifted[7]}}, shifted[7:0]};
            LH:      wb_data = {{16{shifted[15]}}, shifted[15:0]};
            LBU:     wb_data = {24'b0, shifted[7:0]};
            LHU:     wb_data = {16'b0, shifted[15:0]};
            default: wb_data = ld.data;
        endcase
    end

    assign want_to_complete  = (state == ST_OUTPUT);
    assign result.valid      = want_to_complete;
    assign result.dest_pr    = ld.dest_pr;
    assign result.rob_entry  = ld.rob_entry;
    assign result.dest_value = wb_data;

    always_ff @(posedge clock) begin
        if (reset) begin
            state       <= ST_IDLE;
            req_pending <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (accept) state <= ST_LOOKUP;
                end
                ST_LOOKUP: begin
                    if (!fwd.stall) begin // Older stores all resolved
                        if (full_fwd) begin
                            state <= ST_OUTPUT;
                        end else begin
                            state       <= ST_MEM;
                            req_pending <= 1'b1;
                        end
                    end
                end
                ST_MEM: begin
                    if (grant) req_pending <= 1'b0;
                    if (rd_valid) state <= ST_OUTPUT;
                end
                ST_OUTPUT: begin
                    if (!complete_stall) state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            ld.dest_pr   <= issue.dest_pr;
            ld.rob_entry <= issue.rob_entry;
            ld.tail_pos  <= issue.sq_tail;
            ld.addr      <= new_addr;
            ld.op        <= issue.op;
            ld.usebytes  <= new_usebytes;
        end
        if (state == ST_LOOKUP && !fwd.stall) begin
            ld.fwd_bytes <= hit_bytes;
            ld.data      <= fwd.data;
        end
        if (state == ST_MEM && rd_valid) ld.data <= merged;
    end

endmodule

// File: logic/lsq_pkg.sv
package lsq_pkg;

    // Wide enough for the deepest store queue (8 entries)
    localparam int sq_idx_w = 3;

    typedef logic [sq_idx_w-1:0] sq_idx_t;
    typedef logic [5:0]          pr_idx_t;
    typedef logic [4:0]          rob_idx_t;
    typedef logic [isa_pkg::xlen-3:0] word_addr_t;

    typedef struct packed {
        logic                     valid;
        isa_pkg::rv_inst_t        inst;
        logic [isa_pkg::xlen-1:0] base;   // rs1 value
        isa_pkg::ls_op_t          op;
        pr_idx_t                  dest_pr;
        rob_idx_t                 rob_entry;
        sq_idx_t                  sq_tail; // Store queue tail seen at dispatch
    } issue_pkt_t;

    typedef struct packed {
        logic                     valid;
        pr_idx_t                  dest_pr;
        rob_idx_t                 rob_entry;
        logic [isa_pkg::xlen-1:0] dest_value;
    } complete_pkt_t;

    typedef struct packed {
        word_addr_t word_addr;
        sq_idx_t    tail_pos;
    } sq_lookup_t;

    // Forwarded bytes sit in their memory lanes
    typedef struct packed {
        logic                     stall;
        logic [3:0]               usebytes;
        logic [isa_pkg::xlen-1:0] data;
    } sq_result_t;

    typedef struct packed {
        logic                     valid;
        logic                     write;
        word_addr_t               word_addr;
        logic [3:0]               be;
        logic [isa_pkg::xlen-1:0] wdata;
    } mem_req_t;

endpackage

// File: logic/lsu_top.sv
`timescale 1ns/10ps

module lsu_top #(
    parameter int SQ_DEPTH  = 8,
    parameter int MEM_WORDS = 256
) (
    input  logic                   clock,
    input  logic                   reset,
    input  lsq_pkg::issue_pkt_t    load_issue,
    output logic                   load_ready,
    input  logic                   sq_alloc,
    output lsq_pkg::sq_idx_t       sq_alloc_idx,
    input  logic                   sq_resolve,
    input  lsq_pkg::sq_idx_t       sq_resolve_idx,
    input  isa_pkg::rv_inst_t      sq_resolve_inst,
    input  logic [31:0]            sq_resolve_base,
    input  logic [31:0]            sq_resolve_value,
    input  isa_pkg::ls_op_t        sq_resolve_op,
    input  logic                   sq_commit,
    input  logic                   complete_stall,
    output logic                   want_to_complete,
    output lsq_pkg::complete_pkt_t complete,
    output logic                   sq_full
);
    import lsq_pkg::*;

    sq_lookup_t  lookup;
    sq_result_t  fwd;
    mem_req_t    load_req;
    mem_req_t    store_req;
    mem_req_t    mem_req;
    logic        load_grant;
    logic        store_grant;
    logic        rd_valid;
    logic [31:0] rd_data;

    load_unit u_load (
        .clock            (clock),
        .reset            (reset),
        .complete_stall   (complete_stall),
        .issue            (load_issue),
        .ready            (load_ready),
        .want_to_complete (want_to_complete),
        .result           (complete),
        .lookup           (lookup),
        .fwd              (fwd),
        .mem_req          (load_req),
        .grant            (load_grant),
        .rd_valid         (rd_valid),
        .rd_data          (rd_data)
    );

    store_queue #(
        .SQ_DEPTH (SQ_DEPTH)
    ) u_sq (
        .clock         (clock),
        .reset         (reset),
        .alloc         (sq_alloc),
        .alloc_idx     (sq_alloc_idx),
        .full          (sq_full),
        .resolve       (sq_resolve),
        .resolve_idx   (sq_resolve_idx),
        .resolve_inst  (sq_resolve_inst),
        .resolve_base  (sq_resolve_base),
        .resolve_value (sq_resolve_value),
        .resolve_op    (sq_resolve_op),
        .commit        (sq_commit),
        .lookup        (lookup),
        .fwd           (fwd),
        .mem_req       (store_req),
        .grant         (store_grant)
    );

    mem_arbiter u_arb (
        .load_req    (load_req),
        .store_req   (store_req),
        .load_grant  (load_grant),
        .store_grant (store_grant),
        .mem_req     (mem_req)
    );

    data_mem #(
        .MEM_WORDS (MEM_WORDS)
    ) u_mem (
        .clock    (clock),
        .reset    (reset),
        .req      (mem_req),
        .rd_valid (rd_valid),
        .rd_data  (rd_data)
    );

endmodule

// File: logic/mem_arbiter.sv
`timescale 1ns/10ps

module mem_arbiter (
    input  lsq_pkg::mem_req_t load_req,
    input  lsq_pkg::mem_req_t store_req,
    output logic              load_grant,
    output logic              store_grant,
    output lsq_pkg::mem_req_t mem_req
);

    // Loads first, store drain only on an idle port
    always_comb begin
        load_grant  = load_req.valid;
        store_grant = store_req.valid && !load_req.valid;
        if (load_req.valid) begin
            mem_req = load_req;
        end else begin
            mem_req = store_req; // Carries valid low when nobody asks
        end
    end

endmodule

// File: logic/store_queue.sv
`timescale 1ns/10ps

module store_queue #(
    parameter int SQ_DEPTH = 8
) (
    input  logic                clock,
    input  logic                reset,
    input  logic                alloc,
    output lsq_pkg::sq_idx_t    alloc_idx,
    output logic                full,
    input  logic                resolve,
    input  lsq_pkg::sq_idx_t    resolve_idx,
    input  isa_pkg::rv_inst_t   resolve_inst,
    input  logic [31:0]         resolve_base,
    input  logic [31:0]         resolve_value,
    input  isa_pkg::ls_op_t     resolve_op,
    input  logic                commit,
    input  lsq_pkg::sq_lookup_t lookup,
    output lsq_pkg::sq_result_t fwd,
    output lsq_pkg::mem_req_t   mem_req,
    input  logic                grant
);
    import isa_pkg::*;
    import lsq_pkg::*;

    localparam int idx_w = $clog2(SQ_DEPTH);

    typedef logic [idx_w-1:0] ptr_t;

    typedef struct packed {
        word_addr_t      word_addr;
        logic [3:0]      mask;
        logic [xlen-1:0] data;
    } sq_entry_t;

    sq_entry_t           entries [SQ_DEPTH];
    logic [SQ_DEPTH-1:0] resolved;
    logic [SQ_DEPTH-1:0] committed;
    ptr_t                head;
    ptr_t                tail;
    ptr_t                cmt_ptr;   // Oldest entry not yet committed
    logic [idx_w:0]      count;
    ptr_t                res_ptr;
    logic                do_alloc;
    logic [xlen-1:0]     res_addr;
    logic [3:0]          res_mask;
    logic [xlen-1:0]     res_data;

    assign full      = (count == SQ_DEPTH);
    assign alloc_idx = sq_idx_t'(tail);
    assign do_alloc  = alloc && !full;
    assign res_ptr   = resolve_idx[idx_w-1:0];

    assign res_addr = resolve_base + s_imm(resolve_inst);

    // Replicated value puts the data in every lane, mask picks the right one
    always_comb begin
        case (resolve_op)
            SB: begin
                res_mask = 4'b0001 << res_addr[1:0];
                res_data = {4{resolve_value[7:0]}};
            end
            SH: begin
                res_mask = 4'b0011 << res_addr[1:0];
                res_data = {2{resolve_value[15:0]}};
            end
            default: begin
                res_mask = 4'b1111;
                res_data = resolve_value;
            end
        endcase
    end

    // Oldest to youngest, so later stores overwrite earlier bytes
    always_comb begin
        ptr_t idx;
        ptr_t span;
        fwd  = '0;
        span = lookup.tail_pos[idx_w-1:0] - head;
        for (int k = 0; k < SQ_DEPTH; k++) begin
            idx = head + ptr_t'(k);
            if (k < span) begin
                if (!resolved[idx]) begin
                    fwd.stall = 1'b1;
                end else if (entries[idx].word_addr == lookup.word_addr) begin
                    for (int b = 0; b < 4; b++) begin
                        if (entries[idx].mask[b]) begin
                            fwd.usebytes[b]    = 1'b1;
                            fwd.data[8*b +: 8] = entries[idx].data[8*b +: 8];
                        end
                    end
                end
            end
        end
    end

    assign mem_req.valid     = committed[head];
    assign mem_req.write     = 1'b1;
    assign mem_req.word_addr = entries[head].word_addr;
    assign mem_req.be        = entries[head].mask;
    assign mem_req.wdata     = entries[head].data;

    always_ff @(posedge clock) begin
        if (reset) begin
            head      <= '0;
            tail      <= '0;
            cmt_ptr   <= '0;
            count     <= '0;
            resolved  <= '0;
            committed <= '0;
        end else begin
            if (do_alloc) begin
                resolved[tail] <= 1'b0;
                tail           <= tail + 1'b1;
            end
            if (resolve) resolved[res_ptr] <= 1'b1;
            if (commit) begin
                committed[cmt_ptr] <= 1'b1;
                cmt_ptr            <= cmt_ptr + 1'b1;
            end
            if (grant) begin // Write lands on this edge
                committed[head] <= 1'b0;
                head            <= head + 1'b1;
            end
            if (do_alloc && !grant) begin
                count <= count + 1'b1;
            end else if (!do_alloc && grant) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (resolve) begin
            entries[res_ptr].word_addr <= res_addr[xlen-1:2];
            entries[res_ptr].mask      <= res_mask;
            entries[res_ptr].data      <= res_data;
        end
    end

endmodule

// File: tb.f
logic/isa_pkg.sv
logic/lsq_pkg.sv
logic/load_unit.sv
logic/store_queue.sv
logic/mem_arbiter.sv
logic/data_mem.sv
logic/lsu_top.sv
dv/lsu_tb.sv
